/* include/accel_cfg.svh */
`ifndef ACCEL_CFG_SVH
`define ACCEL_CFG_SVH

// ----------------------------------------------------------
// Stream and row geometry
// ----------------------------------------------------------
`define ACCEL_WORD_W      16
`define ACCEL_ROW_WORDS   4
`define ACCEL_ROW_W       64

// ----------------------------------------------------------
// Data memory
// ----------------------------------------------------------
`define ACCEL_MEM_DEPTH   16
`define ACCEL_ROW_ADDR_W  4
// Must hold 0 up to a full memory
`define ACCEL_COUNT_W     5

// Entries per stream FIFO
`define ACCEL_FIFO_DEPTH  2

// Debug bus
`define ACCEL_BUS_W       32
`define ACCEL_BUS_ADDR_W  12

`endif

/* hdl/accel_pkg.sv */
`include "accel_cfg.svh"

package accel_pkg;

    // Vector types with a meaning
    typedef logic [`ACCEL_WORD_W-1:0]     word_t;
    typedef logic [`ACCEL_ROW_W-1:0]      row_t;
    typedef logic [`ACCEL_ROW_ADDR_W-1:0] row_addr_t;
    typedef logic [`ACCEL_COUNT_W-1:0]    row_count_t;
    typedef logic [`ACCEL_BUS_W-1:0]      bus_data_t;
    typedef logic [`ACCEL_BUS_ADDR_W-1:0] bus_addr_t;

    // Run sequencing
    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_LOAD,
        RUN_UNLOAD
    } run_state_e;

    // Loader FSM
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_COUNT,
        LD_FILL
    } loader_state_e;

endpackage

/* hdl/mem_port_if.sv */
interface mem_port_if import accel_pkg::*; ();

    // Client side of the request
    logic      req;
    logic      we;
    row_addr_t addr;
    row_t      wdata;

    // Arbiter answer, rdata one cycle after acceptance
    logic      gnt;
    row_t      rdata;

    modport client (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

/* hdl/stream_fifo.sv */
`include "accel_cfg.svh"

module stream_fifo import accel_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t din,
    input  logic  enq,
    output logic  full_n,
    output word_t dout,
    input  logic  deq,
    output logic  empty_n
);

    localparam int PTR_W = $clog2(`ACCEL_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`ACCEL_FIFO_DEPTH + 1);

    word_t            mem_q [`ACCEL_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_enq;
    logic             do_deq;

    assign full_n  = count != CNT_W'(`ACCEL_FIFO_DEPTH);
    assign empty_n = count != '0;
    assign do_enq  = enq && full_n;
    assign do_deq  = deq && empty_n;
    assign dout    = mem_q[rd_ptr];

    // Wraps correctly for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`ACCEL_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_deq)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq)
            mem_q[wr_ptr] <= din;
    end

    // Producers and consumers must respect full_n and empty_n
    assert property (@(posedge clk) disable iff (rst) !(enq && !full_n))
        else $error("stream_fifo: enqueue while full");
    assert property (@(posedge clk) disable iff (rst) !(deq && !empty_n))
        else $error("stream_fifo: dequeue while empty");

endmodule

/* hdl/row_loader.sv */
`include "accel_cfg.svh"

module row_loader import accel_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       load_start,
    input  word_t      fifo_dout,
    input  logic       fifo_empty_n,
    output logic       fifo_deq,
    mem_port_if.client mem,
    output row_count_t row_count,
    output logic       load_done
);

    localparam int WIDX_W = $clog2(`ACCEL_ROW_WORDS);

    loader_state_e     state;
    row_t              row_q;
    row_addr_t         waddr;
    logic [WIDX_W-1:0] widx;
    logic              req_q;
    logic              last_row;

    // No words taken while a row write is pending
    assign fifo_deq = fifo_empty_n && !req_q && (state != LD_IDLE);
    assign last_row = (row_count_t'(waddr) + row_count_t'(1)) == row_count;

    assign mem.req   = req_q;
    assign mem.we    = 1'b1;
    assign mem.addr  = waddr;
    assign mem.wdata = row_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= LD_IDLE;
            waddr     <= '0;
            widx      <= '0;
            req_q     <= 1'b0;
            row_count <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            case (state)
                LD_IDLE: begin
                    if (load_start)
                        state <= LD_COUNT;
                end
                LD_COUNT: begin
                    if (fifo_empty_n) begin
                        row_count <= fifo_dout[`ACCEL_COUNT_W-1:0];
                        waddr     <= '0;
                        widx      <= '0;
                        if (fifo_dout[`ACCEL_COUNT_W-1:0] == '0) begin
                            load_done <= 1'b1;
                            state     <= LD_IDLE;
                        end else begin
                            state <= LD_FILL;
                        end
                    end
                end
                LD_FILL: begin
                    if (req_q) begin
                        if (mem.gnt) begin
                            req_q <= 1'b0;
                            waddr <= waddr + 1'b1;
                            if (last_row) begin
                                load_done <= 1'b1;
                                state     <= LD_IDLE;
                            end
                        end
                    end else if (fifo_empty_n) begin
                        if (widx == WIDX_W'(`ACCEL_ROW_WORDS - 1)) begin
                            widx  <= '0;
                            req_q <= 1'b1;
                        end else begin
                            widx <= widx + 1'b1;
                        end
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    // Newest word enters at the top, so the first word ends up lowest
    always_ff @(posedge clk) begin
        if (fifo_deq && state == LD_FILL)
            row_q <= {fifo_dout, row_q[`ACCEL_ROW_W-1:`ACCEL_WORD_W]};
    end

    // Count must fit the data memory
    assert property (@(posedge clk) disable iff (rst)
        (state == LD_COUNT && fifo_empty_n) |=> row_count <= row_count_t'(`ACCEL_MEM_DEPTH))
        else $error("row_loader: row count exceeds memory depth");

endmodule

/* hdl/row_unloader.sv */
`include "accel_cfg.svh"

module row_unloader import accel_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       unload_start,
    input  row_count_t unload_count,
    mem_port_if.client mem,
    output word_t      fifo_din,
    output logic       fifo_enq,
    input  logic       fifo_full_n,
    output logic       unload_done
);

    localparam int WIDX_W = $clog2(`ACCEL_ROW_WORDS);

    row_t              row_q;
    row_addr_t         raddr;
    logic [WIDX_W-1:0] widx;
    logic              req_q;
    logic              cap_q;
    logic              have_row;
    logic              last_word;
    logic              last_row;

    assign last_word = widx == WIDX_W'(`ACCEL_ROW_WORDS - 1);
    assign last_row  = (row_count_t'(raddr) + row_count_t'(1)) == unload_count;

    assign fifo_din = row_q[`ACCEL_WORD_W-1:0];
    assign fifo_enq = have_row && fifo_full_n;

    // Fires with the final enqueue, or at once for an empty run
    assign unload_done = (unload_start && unload_count == '0)
                       || (fifo_enq && last_word && last_row);

    // Read-only client
    assign mem.req   = req_q;
    assign mem.we    = 1'b0;
    assign mem.addr  = raddr;
    assign mem.wdata = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            raddr    <= '0;
            widx     <= '0;
            req_q    <= 1'b0;
            cap_q    <= 1'b0;
            have_row <= 1'b0;
        end else begin
            if (unload_start && unload_count != '0) begin
                raddr <= '0;
                req_q <= 1'b1;
            end
            if (req_q && mem.gnt) begin
                req_q <= 1'b0;
                cap_q <= 1'b1;
            end
            // rdata valid one cycle after the grant
            if (cap_q) begin
                cap_q    <= 1'b0;
                have_row <= 1'b1;
                widx     <= '0;
            end
            if (fifo_enq) begin
                widx <= widx + 1'b1;
                if (last_word) begin
                    have_row <= 1'b0;
                    widx     <= '0;
                    // Next read only once the held row is fully sent
                    if (!last_row) begin
                        raddr <= raddr + 1'b1;
                        req_q <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cap_q)
            row_q <= mem.rdata;
        else if (fifo_enq)
            row_q <= row_q >> `ACCEL_WORD_W;
    end

endmodule

/* hdl/data_mem_arbiter.sv */
`include "accel_cfg.svh"

module data_mem_arbiter import accel_pkg::*; (
    input  logic        clk,
    mem_port_if.arbiter loader_port,
    mem_port_if.arbiter unloader_port,
    input  logic        busy,
    input  logic        wbs_debug,
    input  logic        wbs_mem_we,
    input  logic        wbs_mem_re,
    input  bus_addr_t   wbs_mem_addr,
    input  bus_data_t   wbs_mem_wdata,
    output bus_data_t   wbs_mem_rdata
);

    row_t      mem_q [`ACCEL_MEM_DEPTH];
    row_t      rd_q;
    logic      cl_req;
    logic      cl_we;
    row_addr_t cl_addr;
    row_t      cl_wdata;
    logic      dbg_go;
    row_addr_t dbg_row;
    int        dbg_lsb;

    // ----------------------------------------------------------
    // Fixed priority, loader first
    // ----------------------------------------------------------
    assign loader_port.gnt     = loader_port.req;
    assign unloader_port.gnt   = unloader_port.req && !loader_port.req;
    assign loader_port.rdata   = rd_q;
    assign unloader_port.rdata = rd_q;

    assign cl_req = loader_port.req || unloader_port.req;

    always_comb begin
        if (loader_port.req) begin
            cl_we    = loader_port.we;
            cl_addr  = loader_port.addr;
            cl_wdata = loader_port.wdata;
        end else begin
            cl_we    = unloader_port.we;
            cl_addr  = unloader_port.addr;
            cl_wdata = unloader_port.wdata;
        end
    end

    // Debug gets the port only outside a run; bit 0 picks the half
    assign dbg_go  = wbs_debug && !busy && !cl_req;
    assign dbg_row = wbs_mem_addr[`ACCEL_ROW_ADDR_W:1];
    assign dbg_lsb = int'(wbs_mem_addr[0]) * `ACCEL_BUS_W;

    // ----------------------------------------------------------
    // Single-port bank
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (cl_req) begin
            if (cl_we)
                mem_q[cl_addr] <= cl_wdata;
            else
                rd_q <= mem_q[cl_addr];
        end else if (dbg_go && wbs_mem_we) begin
            mem_q[dbg_row][dbg_lsb +: `ACCEL_BUS_W] <= wbs_mem_wdata;
        end else if (dbg_go && wbs_mem_re) begin
            wbs_mem_rdata <= mem_q[dbg_row][dbg_lsb +: `ACCEL_BUS_W];
        end
    end

    // Load and unload phases never overlap
    assert property (@(posedge clk) loader_port.req |-> !unloader_port.req)
        else $error("data_mem_arbiter: loader and unloader request together");

endmodule

/* hdl/run_controller.sv */
module run_controller import accel_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wbs_fsm_start,
    output logic       wbs_fsm_done,
    output logic       busy,
    output logic       load_start,
    input  logic       load_done,
    input  row_count_t row_count,
    output logic       unload_start,
    output row_count_t unload_count,
    input  logic       unload_done
);

    run_state_e state;
    row_count_t count_q;

    // Stays high through the done cycle
    assign busy         = (state != RUN_IDLE) || wbs_fsm_done;
    assign unload_count = count_q;

    // ----------------------------------------------------------
    // Run sequence, start ignored unless idle
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= RUN_IDLE;
            load_start   <= 1'b0;
            unload_start <= 1'b0;
            wbs_fsm_done <= 1'b0;
        end else begin
            load_start   <= 1'b0;
            unload_start <= 1'b0;
            wbs_fsm_done <= 1'b0;
            case (state)
                RUN_IDLE: begin
                    if (wbs_fsm_start) begin
                        state      <= RUN_LOAD;
                        load_start <= 1'b1;
                    end
                end
                RUN_LOAD: begin
                    if (load_done) begin
                        state        <= RUN_UNLOAD;
                        unload_start <= 1'b1;
                    end
                end
                RUN_UNLOAD: begin
                    if (unload_done) begin
                        state        <= RUN_IDLE;
                        wbs_fsm_done <= 1'b1;
                    end
                end
                default: state <= RUN_IDLE;
            endcase
        end
    end

    // Loaded count, valid when unload_start rises
    always_ff @(posedge clk) begin
        if (state == RUN_LOAD && load_done)
            count_q <= row_count;
    end

endmodule

/* hdl/accel_top.sv */
module accel_top import accel_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Stream ports
    input  word_t     input_data,
    input  logic      input_vld,
    output logic      input_rdy,
    output word_t     output_data,
    output logic      output_vld,
    input  logic      output_rdy,
    // Wishbone side
    input  logic      wbs_debug,
    input  logic      wbs_fsm_start,
    output logic      wbs_fsm_done,
    input  logic      wbs_mem_we,
    input  logic      wbs_mem_re,
    input  bus_addr_t wbs_mem_addr,
    input  bus_data_t wbs_mem_wdata,
    output bus_data_t wbs_mem_rdata
);

    word_t      input_fifo_dout;
    logic       input_fifo_empty_n;
    logic       input_fifo_deq;
    word_t      output_fifo_din;
    logic       output_fifo_enq;
    logic       output_fifo_full_n;
    logic       busy;
    logic       load_start;
    logic       load_done;
    row_count_t row_count;
    logic       unload_start;
    row_count_t unload_count;
    logic       unload_done;

    mem_port_if loader_mem ();
    mem_port_if unloader_mem ();

    // ----------------------------------------------------------
    // Stream FIFOs
    // ----------------------------------------------------------
    stream_fifo input_fifo_inst (
        .clk     (clk                   ),
        .rst     (rst                   ),
        .din     (input_data            ),
        .enq     (input_vld && input_rdy),
        .full_n  (input_rdy             ),
        .dout    (input_fifo_dout       ),
        .deq     (input_fifo_deq        ),
        .empty_n (input_fifo_empty_n    )
    );

    stream_fifo output_fifo_inst (
        .clk     (clk                     ),
        .rst     (rst                     ),
        .din     (output_fifo_din         ),
        .enq     (output_fifo_enq         ),
        .full_n  (output_fifo_full_n      ),
        .dout    (output_data             ),
        .deq     (output_rdy && output_vld),
        .empty_n (output_vld              )
    );

    // ----------------------------------------------------------
    // Load, unload and memory
    // ----------------------------------------------------------
    row_loader row_loader_inst (
        .clk          (clk               ),
        .rst          (rst               ),
        .load_start   (load_start        ),
        .fifo_dout    (input_fifo_dout   ),
        .fifo_empty_n (input_fifo_empty_n),
        .fifo_deq     (input_fifo_deq    ),
        .mem          (loader_mem.client ),
        .row_count    (row_count         ),
        .load_done    (load_done         )
    );

    row_unloader row_unloader_inst (
        .clk          (clk                ),
        .rst          (rst                ),
        .unload_start (unload_start       ),
        .unload_count (unload_count       ),
        .mem          (unloader_mem.client),
        .fifo_din     (output_fifo_din    ),
        .fifo_enq     (output_fifo_enq    ),
        .fifo_full_n  (output_fifo_full_n ),
        .unload_done  (unload_done        )
    );

    data_mem_arbiter data_mem_arbiter_inst (
        .clk           (clk                 ),
        .loader_port   (loader_mem.arbiter  ),
        .unloader_port (unloader_mem.arbiter),
        .busy          (busy                ),
        .wbs_debug     (wbs_debug           ),
        .wbs_mem_we    (wbs_mem_we          ),
        .wbs_mem_re    (wbs_mem_re          ),
        .wbs_mem_addr  (wbs_mem_addr        ),
        .wbs_mem_wdata (wbs_mem_wdata       ),
        .wbs_mem_rdata (wbs_mem_rdata       )
    );

    run_controller run_controller_inst (
        .clk           (clk          ),
        .rst           (rst          ),
        .wbs_fsm_start (wbs_fsm_start),
        .wbs_fsm_done  (wbs_fsm_done ),
        .busy          (busy         ),
        .load_start    (load_start   ),
        .load_done     (load_done    ),
        .row_count     (row_count    ),
        .unload_start  (unload_start ),
        .unload_count  (unload_count ),
        .unload_done   (unload_done  )
    );

endmodule

/* dv/accel_tb.sv */
`include "accel_cfg.svh"

module accel_tb import accel_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROW_WORDS = `ACCEL_ROW_WORDS;
    localparam int HALVES    = 2 * `ACCEL_MEM_DEPTH;
    // Longest test moves 65 words at about half rate, so a few hundred
    // cycles each; the limit leaves a wide margin over all six tests
    localparam int MAX_CYCLES = 20000;

    logic      clk;
    logic      rst;
    word_t     input_data;
    logic      input_vld;
    logic      input_rdy;
    word_t     output_data;
    logic      output_vld;
    logic      output_rdy;
    logic      wbs_debug;
    logic      wbs_fsm_start;
    logic      wbs_fsm_done;
    logic      wbs_mem_we;
    logic      wbs_mem_re;
    bus_addr_t wbs_mem_addr;
    bus_data_t wbs_mem_wdata;
    bus_data_t wbs_mem_rdata;

    int error_count  = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycle_count  = 0;
    int done_count   = 0;

    // Words of the current run and the expected memory contents
    word_t     stream_q [$];
    word_t     sent_q [$];
    word_t     got_q [$];
    bus_data_t half_model [HALVES];

    accel_top accel_top_inst (
        .clk           (clk          ),
        .rst           (rst          ),
        .input_data    (input_data   ),
        .input_vld     (input_vld    ),
        .input_rdy     (input_rdy    ),
        .output_data   (output_data  ),
        .output_vld    (output_vld   ),
        .output_rdy    (output_rdy   ),
        .wbs_debug     (wbs_debug    ),
        .wbs_fsm_start (wbs_fsm_start),
        .wbs_fsm_done  (wbs_fsm_done ),
        .wbs_mem_we    (wbs_mem_we   ),
        .wbs_mem_re    (wbs_mem_re   ),
        .wbs_mem_addr  (wbs_mem_addr ),
        .wbs_mem_wdata (wbs_mem_wdata),
        .wbs_mem_rdata (wbs_mem_rdata)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (!rst && wbs_fsm_done)
            done_count <= done_count + 1;
    end

    // ----------------------------------------------------------
    // Reporting
    // ----------------------------------------------------------
    task automatic report_mismatch(input string test, input bus_data_t expected,
                                   input bus_data_t actual);
        $display("ERR %s: expected %h, actual %h", test, expected, actual);
        error_count++;
        test_errors++;
    endtask

    task automatic end_test(input string test);
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", test);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", test, test_errors);
        end
        test_errors = 0;
    endtask

    // ----------------------------------------------------------
    // Stream and bus drivers
    // ----------------------------------------------------------
    task automatic pulse_start();
        @(posedge clk);
        wbs_fsm_start <= 1'b1;
        @(posedge clk);
        wbs_fsm_start <= 1'b0;
    endtask

    // Count word first, then the data words
    task automatic send_words();
        int idx;
        idx = 0;
        @(posedge clk);
        input_data <= stream_q[0];
        input_vld  <= 1'b1;
        while (idx < stream_q.size()) begin
            @(posedge clk);
            if (input_rdy) begin
                idx++;
                if (idx < stream_q.size())
                    input_data <= stream_q[idx];
                else
                    input_vld <= 1'b0;
            end
        end
    endtask

    task automatic collect_words(input int total, input bit toggle);
        while (got_q.size() < total) begin
            @(posedge clk);
            if (output_vld && output_rdy)
                got_q.push_back(output_data);
            if (toggle)
                output_rdy <= 1'($urandom_range(0, 1));
        end
        output_rdy <= 1'b1;
    endtask

    task automatic wait_done();
        do
            @(posedge clk);
        while (!wbs_fsm_done);
    endtask

    task automatic debug_write(input int addr, input bus_data_t value);
        @(posedge clk);
        wbs_debug     <= 1'b1;
        wbs_mem_we    <= 1'b1;
        wbs_mem_addr  <= bus_addr_t'(addr);
        wbs_mem_wdata <= value;
        @(posedge clk);
        wbs_mem_we <= 1'b0;
        wbs_debug  <= 1'b0;
    endtask

    task automatic debug_read(input int addr, output bus_data_t data);
        @(posedge clk);
        wbs_debug    <= 1'b1;
        wbs_mem_re   <= 1'b1;
        wbs_mem_addr <= bus_addr_t'(addr);
        @(posedge clk);
        wbs_mem_re <= 1'b0;
        // Half-row is there from the second cycle on
        @(posedge clk);
        data = wbs_mem_rdata;
        wbs_debug <= 1'b0;
    endtask

    // Output held back so the run stays busy with row 0 already stored,
    // then row 0 is written over the debug port
    task automatic poke_row_during_run();
        output_rdy <= 1'b0;
        do
            @(posedge clk);
        while (!output_vld);
        wbs_debug     <= 1'b1;
        wbs_mem_we    <= 1'b1;
        wbs_mem_addr  <= '0;
        wbs_mem_wdata <= ~{sent_q[1], sent_q[0]};
        @(posedge clk);
        wbs_mem_we <= 1'b0;
        wbs_debug  <= 1'b0;
        output_rdy <= 1'b1;
    endtask

    // Runs one load and unload and checks the output stream
    task automatic run_stream(input string test, input int rows, input bit toggle,
                              input bit poke);
        int done_before;
        int extra;
        int i;
        stream_q.delete();
        sent_q.delete();
        got_q.delete();
        stream_q.push_back(word_t'(rows));
        for (i = 0; i < rows * ROW_WORDS; i++) begin
            sent_q.push_back(word_t'($urandom));
            stream_q.push_back(sent_q[i]);
        end
        done_before = done_count;
        pulse_start();
        fork
            send_words();
            collect_words(rows * ROW_WORDS, toggle);
            wait_done();
            if (poke) poke_row_during_run();
        join
        // Nothing may follow the last word
        extra = 0;
        repeat (8) begin
            @(posedge clk);
            if (output_vld)
                extra++;
        end
        if (extra != 0)
            report_mismatch(test, '0, bus_data_t'(extra));
        for (i = 0; i < got_q.size(); i++) begin
            if (got_q[i] !== sent_q[i])
                report_mismatch(test, bus_data_t'(sent_q[i]), bus_data_t'(got_q[i]));
        end
        if (done_count - done_before != 1)
            report_mismatch(test, 32'd1, bus_data_t'(done_count - done_before));
        // Row r holds words 4r..4r+3, first word lowest
        for (i = 0; i < 2 * rows; i++)
            half_model[i] = {sent_q[2 * i + 1], sent_q[2 * i]};
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------
    task automatic test_after_reset();
        @(posedge clk);
        if (output_vld !== 1'b0)
            report_mismatch("after_reset", '0, bus_data_t'(output_vld));
        if (wbs_fsm_done !== 1'b0)
            report_mismatch("after_reset", '0, bus_data_t'(wbs_fsm_done));
        if (input_rdy !== 1'b1)
            report_mismatch("after_reset", 32'd1, bus_data_t'(input_rdy));
        end_test("after_reset");
    endtask

    task automatic test_debug_read();
        bus_data_t rd;
        int        addr;
        for (addr = 0; addr < HALVES; addr++) begin
            debug_read(addr, rd);
            if (rd !== half_model[addr])
                report_mismatch("debug_read", half_model[addr], rd);
        end
        end_test("debug_read");
    endtask

    task automatic test_debug_write();
        bus_data_t rd;
        bus_data_t value;
        int        addr;
        addr  = int'($urandom_range(0, HALVES - 1));
        value = $urandom;
        debug_write(addr, value);
        half_model[addr] = value;
        debug_read(addr, rd);
        if (rd !== half_model[addr])
            report_mismatch("debug_write", half_model[addr], rd);
        debug_read(addr ^ 1, rd);
        if (rd !== half_model[addr ^ 1])
            report_mismatch("debug_write", half_model[addr ^ 1], rd);
        end_test("debug_write");
    endtask

    task automatic test_debug_blocked();
        bus_data_t rd;
        run_stream("debug_blocked", 1, 1'b0, 1'b1);
        debug_read(0, rd);
        if (rd !== half_model[0])
            report_mismatch("debug_blocked", half_model[0], rd);
        debug_read(1, rd);
        if (rd !== half_model[1])
            report_mismatch("debug_blocked", half_model[1], rd);
        end_test("debug_blocked");
    endtask

    initial begin
        void'($urandom(38));
        clk           = 1'b0;
        rst           = 1'b1;
        input_data    = '0;
        input_vld     = 1'b0;
        output_rdy    = 1'b1;
        wbs_debug     = 1'b0;
        wbs_fsm_start = 1'b0;
        wbs_mem_we    = 1'b0;
        wbs_mem_re    = 1'b0;
        wbs_mem_addr  = '0;
        wbs_mem_wdata = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        test_after_reset();
        run_stream("pass_through", 3, 1'b0, 1'b0);
        end_test("pass_through");
        run_stream("back_pressure", 16, 1'b1, 1'b0);
        end_test("back_pressure");
        test_debug_read();
        test_debug_write();
        test_debug_blocked();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hdl/accel_pkg.sv
hdl/mem_port_if.sv
hdl/stream_fifo.sv
hdl/row_loader.sv
hdl/row_unloader.sv
hdl/data_mem_arbiter.sv
hdl/run_controller.sv
hdl/accel_top.sv
dv/accel_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   := vlog.f
TOP        := accel_tb
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
